// ==== verilog/decodePkg.sv ====
`default_nettype none

package decodePkg;

	// Data and address width of the core
	typedef logic [31:0] word;

	// Raw 32-bit instruction as fetched
	typedef logic [31:0] instrWord;

	// Register index, x0 to x31
	typedef logic [4:0] regAddr;

	// Copy of funct3 for load/store width and sign
	typedef logic [2:0] memKind;

	// Operations the execute stage ALU understands
	typedef enum logic [3:0] {
		aluAdd   = 4'd0,
		aluSub   = 4'd1,
		aluSll   = 4'd2,
		aluSlt   = 4'd3,
		aluSltu  = 4'd4,
		aluXor   = 4'd5,
		aluSrl   = 4'd6,
		aluSra   = 4'd7,
		aluOr    = 4'd8,
		aluAnd   = 4'd9,
		// Operand B straight through, used by LUI
		aluPassB = 4'd10
	} aluOp;

	// Immediate formats
	typedef enum logic [2:0] {
		immNone = 3'd0,
		immI    = 3'd1,
		immS    = 3'd2,
		immB    = 3'd3,
		immU    = 3'd4,
		immJ    = 3'd5
	} immKind;

	// RV32I major opcodes, anything else is illegal here
	typedef enum logic [6:0] {
		opLoad   = 7'b0000011,
		opImm    = 7'b0010011,
		opAuipc  = 7'b0010111,
		opStore  = 7'b0100011,
		opReg    = 7'b0110011,
		opLui    = 7'b0110111,
		opBranch = 7'b1100011,
		opJalr   = 7'b1100111,
		opJal    = 7'b1101111
	} opcodeKind;

	// Execute queue slots, one credit each
	localparam int decodeCredits = 4;
	localparam int creditWidth = $clog2(decodeCredits + 1);

	// Counter has to hold the full value, not just decodeCredits-1
	typedef logic [creditWidth-1:0] creditCount;

endpackage

`default_nettype wire

// ==== verilog/decodeOpIf.sv ====
`timescale 1ns/1ns
`default_nettype none

interface decodeOpIf import decodePkg::*; ();

	// ALU operation, qualified since the field shares the type name
	decodePkg::aluOp aluOp;
	// Operand B from the immediate instead of rs2
	logic immSel;
	// Operand A from the pc instead of rs1
	logic pcOperand;
	// Operand A forced to zero
	logic setDataZero;
	logic memRead;
	logic memWrite;
	memKind memType;
	// Link value is pc plus 4
	logic addConstant4;
	logic regWrite;
	regAddr rd;
	logic illegal;

	modport source (
		output aluOp, immSel, pcOperand, setDataZero, memRead, memWrite,
		output memType, addConstant4, regWrite, rd, illegal
	);

	modport sink (
		input aluOp, immSel, pcOperand, setDataZero, memRead, memWrite,
		input memType, addConstant4, regWrite, rd, illegal
	);

endinterface

`default_nettype wire

// ==== verilog/controlUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnit import decodePkg::*; (
	input  instrWord         instr,
	decodeOpIf.source        ctrl,
	output immKind           kind,
	output logic             branch,
	output logic             jump
);

	// Instruction fields
	opcodeKind opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic legal;

	assign opcode = opcodeKind'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Destination passes through even when regWrite is low
	assign ctrl.rd = instr[11:7];

	// OP and OP-IMM share the funct3 table, alt selects sub or sra
	function automatic aluOp aluFor(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? aluSub : aluAdd;
			3'b001: return aluSll;
			3'b010: return aluSlt;
			3'b011: return aluSltu;
			3'b100: return aluXor;
			3'b101: return alt ? aluSra : aluSrl;
			3'b110: return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	always_comb begin
		// Defaults are a harmless add with nothing written
		ctrl.aluOp = aluAdd;
		ctrl.immSel = 1'b0;
		ctrl.pcOperand = 1'b0;
		ctrl.setDataZero = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memType = '0;
		ctrl.addConstant4 = 1'b0;
		ctrl.regWrite = 1'b0;
		kind = immNone;
		branch = 1'b0;
		jump = 1'b0;
		legal = 1'b1;
		case (opcode)
			opLui: begin
				// 0 + immediate through passB
				ctrl.aluOp = aluPassB;
				ctrl.immSel = 1'b1;
				ctrl.setDataZero = 1'b1;
				ctrl.regWrite = 1'b1;
				kind = immU;
			end
			opAuipc: begin
				ctrl.pcOperand = 1'b1;
				ctrl.immSel = 1'b1;
				ctrl.regWrite = 1'b1;
				kind = immU;
			end
			opJal: begin
				// ALU builds the link value pc + 4
				ctrl.pcOperand = 1'b1;
				ctrl.addConstant4 = 1'b1;
				ctrl.regWrite = 1'b1;
				kind = immJ;
				jump = 1'b1;
			end
			opJalr: begin
				ctrl.pcOperand = 1'b1;
				ctrl.addConstant4 = 1'b1;
				ctrl.regWrite = 1'b1;
				kind = immI;
				jump = 1'b1;
				legal = (funct3 == 3'b000);
			end
			opBranch: begin
				kind = immB;
				branch = 1'b1;
				// funct3 010 and 011 are unused
				legal = !(funct3 inside {3'b010, 3'b011});
			end
			opLoad: begin
				ctrl.immSel = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memType = funct3;
				ctrl.regWrite = 1'b1;
				kind = immI;
				legal = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
			end
			opStore: begin
				ctrl.immSel = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.memType = funct3;
				kind = immS;
				legal = funct3 inside {3'b000, 3'b001, 3'b010};
			end
			opImm: begin
				// Only shifts look at funct7, ADDI has no subtract form
				ctrl.aluOp = aluFor(funct3, (funct3 == 3'b101) && funct7[5]);
				ctrl.immSel = 1'b1;
				ctrl.regWrite = 1'b1;
				kind = immI;
				if (funct3 == 3'b001)
					legal = (funct7 == 7'b0000000);
				else if (funct3 == 3'b101)
					legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
			end
			opReg: begin
				ctrl.aluOp = aluFor(funct3, funct7[5]);
				ctrl.regWrite = 1'b1;
				legal = (funct7 == 7'b0000000) ||
					((funct7 == 7'b0100000) && (funct3 inside {3'b000, 3'b101}));
			end
			// CSR, FENCE, ECALL and the rest
			default: legal = 1'b0;
		endcase
		// Illegal ops must not touch state or redirect fetch
		if (!legal) begin
			ctrl.regWrite = 1'b0;
			ctrl.memRead = 1'b0;
			ctrl.memWrite = 1'b0;
			branch = 1'b0;
			jump = 1'b0;
		end
		ctrl.illegal = !legal;
	end

endmodule

`default_nettype wire

// ==== verilog/immediateExtend.sv ====
`timescale 1ns/1ns
`default_nettype none

module immediateExtend import decodePkg::*; (
	input  instrWord instr,
	input  immKind   kind,
	output word      immediate
);

	// Sign bit is always instr[31] in RV32I
	logic sign;

	assign sign = instr[31];

	always_comb begin
		case (kind)
			// Loads, OP-IMM, JALR
			immI: immediate = {{20{sign}}, instr[31:20]};
			// Stores split the field around rd
			immS: immediate = {{20{sign}}, instr[31:25], instr[11:7]};
			// Branch offsets, bit 0 implied zero
			immB: immediate = {{19{sign}}, sign, instr[7], instr[30:25],
				instr[11:8], 1'b0};
			// LUI and AUIPC, upper 20 bits only
			immU: immediate = {instr[31:12], 12'b0};
			// JAL offset, bit 0 implied zero
			immJ: immediate = {{11{sign}}, sign, instr[19:12], instr[20],
				instr[30:21], 1'b0};
			default: immediate = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerFile import decodePkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  regAddr rs1,
	input  regAddr rs2,
	input  regAddr wbRd,
	input  logic   wbEnable,
	input  word    wbData,
	output word    rs1Data,
	output word    rs2Data
);

	word regs [32];
	// Same-cycle write hits on each read port
	logic bypass1;
	logic bypass2;

	// x0 is never written so it stays at its reset zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEnable && (wbRd != '0)) begin
			regs[wbRd] <= wbData;
		end
	end

	// Forward writeback data, but never onto x0
	assign bypass1 = wbEnable && (wbRd == rs1) && (rs1 != '0);
	assign bypass2 = wbEnable && (wbRd == rs2) && (rs2 != '0);

	assign rs1Data = bypass1 ? wbData : regs[rs1];
	assign rs2Data = bypass2 ? wbData : regs[rs2];

endmodule

`default_nettype wire

// ==== verilog/branchUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module branchUnit import decodePkg::*; (
	input  logic     branch,
	input  logic     jump,
	input  word      pc,
	input  word      pcPlus4,
	input  word      immediate,
	input  word      rs1Data,
	input  word      rs2Data,
	input  instrWord instr,
	output logic     takeBranch,
	output word      branchTarget
);

	opcodeKind opcode;
	logic [2:0] funct3;
	// Branch compare result for the current funct3
	logic condition;
	word pcTarget;
	word jalrSum;

	assign opcode = opcodeKind'(instr[6:0]);
	assign funct3 = instr[14:12];

	// Branches and JAL are pc relative
	assign pcTarget = pc + immediate;
	assign jalrSum = rs1Data + immediate;

	always_comb begin
		case (funct3)
			3'b000: condition = (rs1Data == rs2Data);
			3'b001: condition = (rs1Data != rs2Data);
			3'b100: condition = ($signed(rs1Data) < $signed(rs2Data));
			3'b101: condition = ($signed(rs1Data) >= $signed(rs2Data));
			3'b110: condition = (rs1Data < rs2Data);
			3'b111: condition = (rs1Data >= rs2Data);
			// Reserved encodings never take
			default: condition = 1'b0;
		endcase
	end

	always_comb begin
		// Not taken falls through to the next instruction
		takeBranch = 1'b0;
		branchTarget = pcPlus4;
		if (jump) begin
			takeBranch = 1'b1;
			// JALR drops bit 0 of the sum
			if (opcode == opJalr)
				branchTarget = {jalrSum[31:1], 1'b0};
			else
				branchTarget = pcTarget;
		end else if (branch && condition) begin
			takeBranch = 1'b1;
			branchTarget = pcTarget;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/issueCredit.sv ====
`timescale 1ns/1ns
`default_nettype none

module issueCredit import decodePkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  logic            instrValid,
	input  logic            creditReturn,
	decodeOpIf.sink         ctrl,
	input  word             rs1Data,
	input  word             rs2Data,
	input  word             immediate,
	input  word             branchTarget,
	input  logic            takeBranch,
	output logic            instrReady,
	output logic            opValid,
	output decodePkg::aluOp aluOp,
	output logic            immSel,
	output logic            pcOperand,
	output logic            setDataZero,
	output logic            memRead,
	output logic            memWrite,
	output memKind          memType,
	output logic            addConstant4,
	output logic            regWrite,
	output regAddr          rd,
	output logic            illegal,
	output word             opRs1Data,
	output word             opRs2Data,
	output word             opImmediate,
	output logic            opTakeBranch,
	output word             opBranchTarget
);

	// Free execute queue slots
	creditCount credits;
	logic accept;

	assign instrReady = (credits != '0);
	assign accept = instrValid && instrReady;

	// Issue and return in one cycle cancel out
	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= creditCount'(decodeCredits);
		end else if (accept && !creditReturn) begin
			credits <= credits - creditCount'(1);
		end else if (!accept && creditReturn && (credits != creditCount'(decodeCredits))) begin
			credits <= credits + creditCount'(1);
		end
	end

	// Valid and redirect last one cycle only
	always_ff @(posedge clk) begin
		if (reset) begin
			opValid <= 1'b0;
			opTakeBranch <= 1'b0;
		end else begin
			opValid <= accept;
			opTakeBranch <= accept && takeBranch;
		end
	end

	// Payload only moves on accept
	always_ff @(posedge clk) begin
		if (accept) begin
			aluOp <= ctrl.aluOp;
			immSel <= ctrl.immSel;
			pcOperand <= ctrl.pcOperand;
			setDataZero <= ctrl.setDataZero;
			memRead <= ctrl.memRead;
			memWrite <= ctrl.memWrite;
			memType <= ctrl.memType;
			addConstant4 <= ctrl.addConstant4;
			regWrite <= ctrl.regWrite;
			rd <= ctrl.rd;
			illegal <= ctrl.illegal;
			opRs1Data <= rs1Data;
			opRs2Data <= rs2Data;
			opImmediate <= immediate;
			opBranchTarget <= branchTarget;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStage import decodePkg::*; (
	input  logic            clk,
	input  logic            reset,
	// Fetch side
	input  instrWord        instr,
	input  word             pc,
	input  word             pcPlus4,
	input  logic            instrValid,
	output logic            instrReady,
	// Writeback port
	input  regAddr          wbRd,
	input  logic            wbEnable,
	input  word             wbData,
	// Execute side
	input  logic            creditReturn,
	output logic            opValid,
	output decodePkg::aluOp aluOp,
	output logic            immSel,
	output logic            pcOperand,
	output logic            setDataZero,
	output logic            memRead,
	output logic            memWrite,
	output memKind          memType,
	output logic            addConstant4,
	output logic            regWrite,
	output regAddr          rd,
	output logic            illegal,
	output word             rs1Data,
	output word             rs2Data,
	output word             immediate,
	output logic            takeBranch,
	output word             branchTarget
);

	// Combinational decode results ahead of the issue register
	decodeOpIf decodedOp ();
	immKind kind;
	logic branch;
	logic jump;
	word readData1;
	word readData2;
	word extImmediate;
	logic resolvedTake;
	word resolvedTarget;

	controlUnit controlUnit_i (
		.instr(instr), .ctrl(decodedOp.source), .kind(kind),
		.branch(branch), .jump(jump)
	);

	immediateExtend immediateExtend_i (
		.instr(instr), .kind(kind), .immediate(extImmediate)
	);

	// Source fields sliced straight from the instruction
	registerFile registerFile_i (
		.clk(clk), .reset(reset),
		.rs1(instr[19:15]), .rs2(instr[24:20]),
		.wbRd(wbRd), .wbEnable(wbEnable), .wbData(wbData),
		.rs1Data(readData1), .rs2Data(readData2)
	);

	branchUnit branchUnit_i (
		.branch(branch), .jump(jump), .pc(pc), .pcPlus4(pcPlus4),
		.immediate(extImmediate), .rs1Data(readData1), .rs2Data(readData2),
		.instr(instr), .takeBranch(resolvedTake), .branchTarget(resolvedTarget)
	);

	issueCredit issueCredit_i (
		.clk(clk), .reset(reset),
		.instrValid(instrValid), .creditReturn(creditReturn), .ctrl(decodedOp.sink),
		.rs1Data(readData1), .rs2Data(readData2), .immediate(extImmediate),
		.branchTarget(resolvedTarget), .takeBranch(resolvedTake),
		.instrReady(instrReady), .opValid(opValid),
		.aluOp(aluOp), .immSel(immSel), .pcOperand(pcOperand),
		.setDataZero(setDataZero), .memRead(memRead), .memWrite(memWrite),
		.memType(memType), .addConstant4(addConstant4), .regWrite(regWrite),
		.rd(rd), .illegal(illegal),
		.opRs1Data(rs1Data), .opRs2Data(rs2Data), .opImmediate(immediate),
		.opTakeBranch(takeBranch), .opBranchTarget(branchTarget)
	);

endmodule

`default_nettype wire

// ==== dv/decodeStage_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStage_sva import decodePkg::*; (
	input logic       clk,
	input logic       reset,
	input logic       creditReturn,
	input logic       instrReady,
	input logic       opValid,
	input creditCount credits
);

	// An issued op held a credit and used it up unless a return came in
	creditForIssue: assert property (@(posedge clk) disable iff (reset)
		opValid |-> ($past(credits) != '0) &&
			((credits == $past(credits) - creditCount'(1)) || $past(creditReturn)))
		else $error("opValid raised without consuming a held credit");

	// Returns never push the count past the queue depth
	creditBound: assert property (@(posedge clk) disable iff (reset)
		credits <= creditCount'(decodeCredits))
		else $error("credit count above the execute queue depth");

	// A return while empty reopens fetch on the next cycle
	zeroCreditReturn: assert property (@(posedge clk) disable iff (reset)
		(credits == '0) && creditReturn |=> instrReady)
		else $error("instrReady stayed low after a credit came back");

endmodule

bind issueCredit decodeStage_sva decodeStage_sva_i (
	.clk(clk), .reset(reset), .creditReturn(creditReturn), .instrReady(instrReady),
	.opValid(opValid), .credits(credits)
);

`default_nettype wire

// ==== dv/decodeStageTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStageTb import decodePkg::*; ();

	localparam int clkPeriod = 100;
	localparam int aluCount = 300;
	localparam int memCount = 300;
	localparam int branchCount = 300;
	localparam int creditRunCount = 100;
	// Directed writeback ops plus the back-pressure burst, with room to spare
	localparam int totalInstr = aluCount + memCount + branchCount + creditRunCount + 16;
	localparam creditCount fullCredits = creditCount'(decodeCredits);

	// Expected contents of one issued op
	typedef struct packed {
		aluOp alu;
		logic immSel;
		logic pcOperand;
		logic setDataZero;
		logic memRead;
		logic memWrite;
		memKind memType;
		logic addConstant4;
		logic regWrite;
		regAddr rd;
		logic illegal;
		word rs1Data;
		word rs2Data;
		word imm;
		logic take;
		word target;
	} expectedOp;

	logic clk;
	logic reset;
	instrWord instr;
	word pc;
	word pcPlus4;
	logic instrValid;
	logic instrReady;
	regAddr wbRd;
	logic wbEnable;
	word wbData;
	logic creditReturn;
	logic opValid;
	aluOp issuedAlu;
	logic immSel;
	logic pcOperand;
	logic setDataZero;
	logic memRead;
	logic memWrite;
	memKind memType;
	logic addConstant4;
	logic regWrite;
	regAddr rd;
	logic illegal;
	word rs1Data;
	word rs2Data;
	word immediate;
	logic takeBranch;
	word branchTarget;

	// Reference state
	word shadow [32];
	creditCount modelCredits;
	expectedOp pending [$];
	logic acceptedLast;
	// Ops seen leaving the DUT
	int acceptCount;
	string testName;

	decodeStage decodeStage_i (
		.clk(clk), .reset(reset), .instr(instr), .pc(pc), .pcPlus4(pcPlus4),
		.instrValid(instrValid), .instrReady(instrReady),
		.wbRd(wbRd), .wbEnable(wbEnable), .wbData(wbData),
		.creditReturn(creditReturn), .opValid(opValid), .aluOp(issuedAlu),
		.immSel(immSel), .pcOperand(pcOperand), .setDataZero(setDataZero),
		.memRead(memRead), .memWrite(memWrite), .memType(memType),
		.addConstant4(addConstant4), .regWrite(regWrite), .rd(rd), .illegal(illegal),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .immediate(immediate),
		.takeBranch(takeBranch), .branchTarget(branchTarget)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Twenty clocks per instruction is far beyond the worst stall
	initial begin
		#(totalInstr * 20 * clkPeriod);
		$display("Timeout: the DUT stopped accepting or issuing instructions");
		$display("Finished with errors");
		$fatal(1);
	end

	task automatic abortRun();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic checkWord(input string what, input word expected, input word actual);
		if (expected !== actual) begin
			$display("[FAIL] %s %s: expected %h actual %h", testName, what, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkAluOp(input string what, input aluOp expected, input aluOp actual);
		if (expected !== actual) begin
			$display("[FAIL] %s %s: expected %s actual %0d", testName, what,
				expected.name(), actual);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string what, input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("[FAIL] %s %s: expected %b actual %b", testName, what, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkMemKind(input string what, input memKind expected, input memKind actual);
		if (expected !== actual) begin
			$display("[FAIL] %s %s: expected %b actual %b", testName, what, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkRegAddr(input string what, input regAddr expected, input regAddr actual);
		if (expected !== actual) begin
			$display("[FAIL] %s %s: expected x%0d actual x%0d", testName, what, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkCredit(input creditCount expCount, input logic ready);
		if ((expCount != '0) !== ready) begin
			$display("[FAIL] %s instrReady: expected %b actual %b with %0d credits", testName,
				expCount != '0, ready, expCount);
			abortRun();
		end
	endtask

	// Shared funct3 table of OP and OP-IMM
	function automatic aluOp aluModel(input logic [2:0] f3, input logic alt);
		aluOp result;
		case (f3)
			3'b000: result = aluAdd;
			3'b001: result = aluSll;
			3'b010: result = aluSlt;
			3'b011: result = aluSltu;
			3'b100: result = aluXor;
			3'b101: result = aluSrl;
			3'b110: result = aluOr;
			default: result = aluAnd;
		endcase
		// Bit 30 only matters for add and right shift
		if (alt && f3 == 3'b000)
			result = aluSub;
		if (alt && f3 == 3'b101)
			result = aluSra;
		return result;
	endfunction

	// RV32I decode reference, a and b are the source values seen this cycle
	function automatic expectedOp decodeModel(input instrWord i, input word pcIn,
			input word pcP4, input word a, input word b);
		expectedOp e;
		logic [6:0] op;
		logic [2:0] f3;
		logic [6:0] f7;
		logic ok;
		logic cond;
		word immI;
		word immS;
		word immB;
		word immU;
		word immJ;
		op = i[6:0];
		f3 = i[14:12];
		f7 = i[31:25];
		immI = {{20{i[31]}}, i[31:20]};
		immS = {{20{i[31]}}, i[31:25], i[11:7]};
		immB = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
		immU = {i[31:12], 12'h000};
		immJ = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
		e = '0;
		e.alu = aluAdd;
		e.rd = i[11:7];
		e.rs1Data = a;
		e.rs2Data = b;
		e.target = pcP4;
		ok = 1'b1;
		case (op)
			opLui: begin
				e.alu = aluPassB;
				e.immSel = 1'b1;
				e.setDataZero = 1'b1;
				e.regWrite = 1'b1;
				e.imm = immU;
			end
			opAuipc: begin
				e.pcOperand = 1'b1;
				e.immSel = 1'b1;
				e.regWrite = 1'b1;
				e.imm = immU;
			end
			opJal: begin
				e.pcOperand = 1'b1;
				e.addConstant4 = 1'b1;
				e.regWrite = 1'b1;
				e.imm = immJ;
				e.take = 1'b1;
				e.target = pcIn + immJ;
			end
			opJalr: begin
				e.pcOperand = 1'b1;
				e.addConstant4 = 1'b1;
				e.regWrite = 1'b1;
				e.imm = immI;
				ok = (f3 == 3'b000);
				e.take = 1'b1;
				e.target = (a + immI) & ~32'd1;
			end
			opBranch: begin
				e.imm = immB;
				ok = (f3[2:1] != 2'b01);
				case (f3)
					3'b000: cond = (a == b);
					3'b001: cond = !(a == b);
					3'b100: cond = $signed(a) < $signed(b);
					3'b101: cond = !($signed(a) < $signed(b));
					3'b110: cond = a < b;
					default: cond = !(a < b);
				endcase
				e.take = cond;
				if (cond)
					e.target = pcIn + immB;
			end
			opLoad: begin
				e.immSel = 1'b1;
				e.memRead = 1'b1;
				e.memType = f3;
				e.regWrite = 1'b1;
				e.imm = immI;
				ok = (f3 != 3'b011) && (f3 != 3'b110) && (f3 != 3'b111);
			end
			opStore: begin
				e.immSel = 1'b1;
				e.memWrite = 1'b1;
				e.memType = f3;
				e.imm = immS;
				ok = !f3[2] && (f3 != 3'b011);
			end
			opImm: begin
				e.alu = aluModel(f3, f3 == 3'b101 && f7[5]);
				e.immSel = 1'b1;
				e.regWrite = 1'b1;
				e.imm = immI;
				if (f3 == 3'b001)
					ok = (f7 == 7'h00);
				else if (f3 == 3'b101)
					ok = (f7 == 7'h00) || (f7 == 7'h20);
			end
			opReg: begin
				e.alu = aluModel(f3, f7[5]);
				e.regWrite = 1'b1;
				ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
			end
			default: ok = 1'b0;
		endcase
		// Illegal ops write nothing and never redirect
		if (!ok) begin
			e.regWrite = 1'b0;
			e.memRead = 1'b0;
			e.memWrite = 1'b0;
			e.take = 1'b0;
			e.target = pcP4;
		end
		e.illegal = !ok;
		return e;
	endfunction

	// mix 0 ALU ops, 1 memory/upper/raw words, 2 branches and jumps
	function automatic instrWord makeInstr(input int mix);
		instrWord w;
		int sel;
		w = $urandom();
		sel = $urandom() % 8;
		if (mix == 0) begin
			w[6:0] = (sel <= 3) ? opReg : opImm;
			// Mostly legal funct7, raw on sel 3 and 7
			if (sel <= 2 || (sel >= 4 && sel <= 6 && w[13:12] == 2'b01))
				w[31:25] = {1'b0, w[30], 5'b00000};
		end else if (mix == 1) begin
			if (sel <= 1)
				w[6:0] = opLoad;
			else if (sel <= 3)
				w[6:0] = opStore;
			else if (sel == 4)
				w[6:0] = opLui;
			else if (sel == 5)
				w[6:0] = opAuipc;
		end else begin
			if (sel <= 4) begin
				w[6:0] = opBranch;
				// Equal operands now and then
				if (sel == 0)
					w[24:20] = w[19:15];
			end else if (sel == 5) begin
				w[6:0] = opJal;
			end else begin
				w[6:0] = opJalr;
				if (sel == 6)
					w[14:12] = 3'b000;
			end
		end
		return w;
	endfunction

	// Outputs registered at the last rising edge
	task automatic checkOutputs();
		expectedOp e;
		checkFlag("opValid", acceptedLast, opValid);
		if (!opValid) begin
			checkFlag("idle takeBranch", 1'b0, takeBranch);
		end else begin
			acceptCount++;
			e = pending.pop_front();
			checkAluOp("aluOp", e.alu, issuedAlu);
			checkFlag("immSel", e.immSel, immSel);
			checkFlag("pcOperand", e.pcOperand, pcOperand);
			checkFlag("setDataZero", e.setDataZero, setDataZero);
			checkFlag("memRead", e.memRead, memRead);
			checkFlag("memWrite", e.memWrite, memWrite);
			checkMemKind("memType", e.memType, memType);
			checkFlag("addConstant4", e.addConstant4, addConstant4);
			checkFlag("regWrite", e.regWrite, regWrite);
			checkRegAddr("rd", e.rd, rd);
			checkFlag("illegal", e.illegal, illegal);
			checkWord("rs1Data", e.rs1Data, rs1Data);
			checkWord("rs2Data", e.rs2Data, rs2Data);
			checkWord("immediate", e.imm, immediate);
			checkFlag("takeBranch", e.take, takeBranch);
			checkWord("branchTarget", e.target, branchTarget);
		end
	endtask

	// One clock: check last results, drive on the falling edge, advance the model
	task automatic cycle(input instrWord i, input logic v, input regAddr wRd, input logic wEn,
			input word wData, input logic cRet, output logic accepted);
		word pcNow;
		word a;
		word b;
		regAddr s1;
		regAddr s2;
		@(negedge clk);
		checkOutputs();
		checkCredit(modelCredits, instrReady);
		pcNow = $urandom();
		pcNow[1:0] = 2'b00;
		instr = i;
		pc = pcNow;
		pcPlus4 = pcNow + 32'd4;
		instrValid = v;
		wbRd = wRd;
		wbEnable = wEn;
		wbData = wData;
		creditReturn = cRet;
		s1 = i[19:15];
		s2 = i[24:20];
		// Same-cycle writeback reaches a nonzero source
		a = (wEn && wRd == s1 && s1 != '0) ? wData : shadow[s1];
		b = (wEn && wRd == s2 && s2 != '0) ? wData : shadow[s2];
		accepted = v && (modelCredits != '0);
		if (accepted) begin
			pending.push_back(decodeModel(i, pcNow, pcNow + 32'd4, a, b));
		end
		if (accepted && !cRet)
			modelCredits = modelCredits - creditCount'(1);
		else if (!accepted && cRet && modelCredits != fullCredits)
			modelCredits = modelCredits + creditCount'(1);
		if (wEn && wRd != '0)
			shadow[wRd] = wData;
		acceptedLast = accepted;
	endtask

	// Random traffic, fetch holds an instruction until it is taken
	task automatic runRandom(input int count, input int mix);
		instrWord cur;
		logic acc;
		logic cRet;
		int done;
		done = 0;
		cur = makeInstr(mix);
		while (done < count) begin
			cRet = (modelCredits != fullCredits) && ($urandom() % 2 == 0);
			cycle(cur, $urandom() % 8 != 0, regAddr'($urandom()), $urandom() % 2 == 0,
				$urandom(), cRet, acc);
			if (acc) begin
				done++;
				cur = makeInstr(mix);
			end
		end
	endtask

	task automatic issueInstr(input instrWord i, input regAddr wRd, input logic wEn,
			input word wData);
		logic acc;
		acc = 1'b0;
		while (!acc)
			cycle(i, 1'b1, wRd, wEn, wData, modelCredits != fullCredits, acc);
	endtask

	task automatic runWriteback();
		instrWord readX0;
		instrWord readX7;
		readX0 = {7'h00, 5'd0, 5'd0, 3'b000, 5'd1, opReg};
		readX7 = {7'h00, 5'd7, 5'd7, 3'b000, 5'd2, opReg};
		// Write to x0 must neither land nor bypass
		issueInstr(readX0, 5'd0, 1'b1, 32'hdeadbeef);
		issueInstr(readX0, 5'd0, 1'b0, '0);
		// New x7 value forwarded while it is being read
		issueInstr(readX7, 5'd7, 1'b1, $urandom());
		issueInstr(readX7, 5'd0, 1'b0, '0);
	endtask

	task automatic runBackPressure();
		instrWord cur;
		logic acc;
		// Refill, extra returns while full must be ignored
		repeat (decodeCredits + 2)
			cycle(32'h0000_0013, 1'b0, '0, 1'b0, '0, 1'b1, acc);
		acceptCount = 0;
		cur = makeInstr(0);
		repeat (decodeCredits + 4) begin
			cycle(cur, 1'b1, '0, 1'b0, '0, 1'b0, acc);
			if (acc)
				cur = makeInstr(0);
		end
		checkWord("accepted without returns", word'(decodeCredits), word'(acceptCount));
		checkCredit(creditCount'(0), instrReady);
		runRandom(creditRunCount, 0);
	endtask

	initial begin
		logic acc;
		reset = 1'b1;
		instr = '0;
		pc = '0;
		pcPlus4 = '0;
		instrValid = 1'b0;
		wbRd = '0;
		wbEnable = 1'b0;
		wbData = '0;
		creditReturn = 1'b0;
		acceptedLast = 1'b0;
		acceptCount = 0;
		modelCredits = fullCredits;
		for (int r = 0; r < 32; r++)
			shadow[r] = '0;
		void'($urandom(92218));
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		testName = "reset";
		checkFlag("opValid", 1'b0, opValid);
		checkFlag("takeBranch", 1'b0, takeBranch);
		checkCredit(fullCredits, instrReady);
		testName = "aluOps";
		runRandom(aluCount, 0);
		testName = "memoryAndUpper";
		runRandom(memCount, 1);
		testName = "branches";
		runRandom(branchCount, 2);
		testName = "writeback";
		runWriteback();
		testName = "backPressure";
		runBackPressure();
		// Drain the last op
		testName = "drain";
		cycle(32'h0000_0013, 1'b0, '0, 1'b0, '0, 1'b0, acc);
		cycle(32'h0000_0013, 1'b0, '0, 1'b0, '0, 1'b0, acc);
		if (pending.size() != 0) begin
			$display("Operations were accepted but never came out of the DUT");
			abortRun();
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/decodePkg.sv
verilog/decodeOpIf.sv
verilog/controlUnit.sv
verilog/immediateExtend.sv
verilog/registerFile.sv
verilog/branchUnit.sv
verilog/issueCredit.sv
verilog/decodeStage.sv
dv/decodeStage_sva.sv
dv/decodeStageTb.sv

// ==== Makefile ====
TOP = decodeStageTb

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
